// ==== verilog/vdma_regs_pkg.sv ====
// VDMA register block definitions
package vdma_regs_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths and fixed values
   ////////////////////////////////////////////////////////////////////////////
   localparam int reg_off_w       = 8;    // Low address bits decoded
   localparam int data_w          = 32;
   localparam int irq_w           = 5;    // Interrupt sources
   localparam int rst_stretch_len = 4;    // Cycles of stretched reset
   localparam int rd_lat          = 3;    // Read request to read data
   localparam logic [data_w-1:0] ip_version = 32'h0001_0000;
   localparam logic [1:0]        resp_okay  = 2'b00;   // AXI OKAY

   typedef logic [reg_off_w-1:0] reg_off_t;

   // Register map
   localparam reg_off_t off_ip_ver      = 8'h00;   // RO
   localparam reg_off_t off_ctrl        = 8'h04;   // RW
   localparam reg_off_t off_glbl_int_en = 8'h08;   // RW
   localparam reg_off_t off_int_status  = 8'h0C;   // RO, write clears
   localparam reg_off_t off_int_en      = 8'h10;   // RW
   localparam reg_off_t off_buff_addr   = 8'h1C;   // WO, FIFO push
   localparam reg_off_t off_frame_size  = 8'h24;   // RO, FIFO pop

   ////////////////////////////////////////////////////////////////////////////
   // Register word views
   ////////////////////////////////////////////////////////////////////////////
   typedef union packed {
      logic [data_w-1:0] raw;
      struct packed {
         logic [data_w-4:0] unused;
         logic              fifo_rst;   // Self clearing
         logic              ip_rst;     // Self clearing
         logic              ip_en;
      } ctrl_fields;
      struct packed {
         logic [data_w-irq_w-1:0] unused;
         logic [irq_w-1:0]        mask;   // One bit per source
      } irq_fields;
   } reg_word_u;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and register side bundles
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic              awvalid;
      logic [data_w-1:0] awaddr;
      logic              wvalid;
      logic [data_w-1:0] wdata;
      logic              bready;
      logic              arvalid;
      logic [data_w-1:0] araddr;
      logic              rready;
   } axil_req_t;

   typedef struct packed {
      logic              awready;
      logic              wready;
      logic              bvalid;
      logic [1:0]        bresp;
      logic              arready;
      logic              rvalid;
      logic [data_w-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic              valid;   // High for the W handshake cycle
      reg_off_t          off;
      logic [data_w-1:0] data;
   } reg_wr_t;

   typedef struct packed {
      logic     req;              // Single cycle
      reg_off_t off;
   } reg_rd_t;

   typedef struct packed {
      logic              buff_addr_wen;
      logic [data_w-1:0] buff_addr_data;
      logic [irq_w-1:0]  int_status_clr;
      logic [irq_w-1:0]  int_en;
      logic              glbl_int_en;
      logic              fifo_rstn;
      logic              ip_rstn;
      logic              ip_en;
   } dma_ctrl_t;

   typedef struct packed {
      logic              frame_size_empty;
      logic [data_w-1:0] frame_size;
      logic [irq_w-1:0]  int_status;
   } dma_status_t;

endpackage

// ==== verilog/vdma_axil_slave.sv ====
// AXI4-Lite slave front end
module vdma_axil_slave (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  vdma_regs_pkg::axil_req_t         axil_req,
   output vdma_regs_pkg::axil_rsp_t         axil_rsp,
   output vdma_regs_pkg::reg_wr_t           reg_wr,
   output vdma_regs_pkg::reg_rd_t           reg_rd,
   input  logic [vdma_regs_pkg::data_w-1:0] rd_data,
   input  logic                             rd_valid
);
   import vdma_regs_pkg::*;

   logic     awready;
   logic     wready;
   logic     bvalid;
   logic     arready;
   logic     rvalid;
   logic     aw_hs;        // Handshake strobes
   logic     w_hs;
   logic     b_hs;
   logic     ar_hs;
   logic     r_hs;
   logic     rd_req_q;
   reg_off_t aw_off_q;     // Latched offsets
   reg_off_t ar_off_q;

   assign aw_hs = axil_req.awvalid & awready;
   assign w_hs  = axil_req.wvalid & wready;
   assign b_hs  = bvalid & axil_req.bready;
   assign ar_hs = axil_req.arvalid & arready;
   assign r_hs  = rvalid & axil_req.rready;

   ////////////////////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         awready <= 1'b1;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         if (b_hs)
            awready <= 1'b1;                 // Reopen after response taken
         else if (aw_hs)
            awready <= 1'b0;
         if (w_hs)
            wready <= 1'b0;
         else if (aw_hs)
            wready <= 1'b1;                  // Data phase one cycle later
         if (b_hs)
            bvalid <= 1'b0;
         else if (w_hs)
            bvalid <= 1'b1;                  // Held until bready
      end
   end

   always_ff @(posedge aclk) begin
      if (aw_hs)
         aw_off_q <= axil_req.awaddr[reg_off_w-1:0];
   end

   // Register write happens on the W handshake itself
   assign reg_wr = '{valid: w_hs, off: aw_off_q, data: axil_req.wdata};

   ////////////////////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         arready  <= 1'b1;
         rd_req_q <= 1'b0;
         rvalid   <= 1'b0;
      end else begin
         rd_req_q <= ar_hs;                  // Request pulse after AR edge
         if (r_hs)
            arready <= 1'b1;
         else if (ar_hs)
            arready <= 1'b0;
         if (r_hs)
            rvalid <= 1'b0;
         else if (rd_valid)
            rvalid <= 1'b1;                  // Data from register file
      end
   end

   always_ff @(posedge aclk) begin
      if (ar_hs)
         ar_off_q <= axil_req.araddr[reg_off_w-1:0];
   end

   assign reg_rd = '{req: rd_req_q, off: ar_off_q};

   // Both responses always OKAY, rdata straight from the register file
   assign axil_rsp = '{
      awready: awready,
      wready:  wready,
      bvalid:  bvalid,
      bresp:   resp_okay,
      arready: arready,
      rvalid:  rvalid,
      rdata:   rd_data,
      rresp:   resp_okay
   };

endmodule

// ==== verilog/vdma_reg_write.sv ====
// VDMA writable registers
module vdma_reg_write (
   input  logic                     aclk,
   input  logic                     aresetn,
   input  vdma_regs_pkg::reg_wr_t   reg_wr,
   output vdma_regs_pkg::dma_ctrl_t dma_ctrl
);
   import vdma_regs_pkg::*;

   localparam int ip_idx   = 0;   // Stretcher lanes
   localparam int fifo_idx = 1;

   reg_word_u         wr_word;
   logic              wr_ctrl;
   logic              wr_glbl;
   logic              wr_int_en;
   logic              wr_int_stat;
   logic              wr_buff;
   logic              ip_en_q;
   logic              glbl_int_en_q;
   logic [irq_w-1:0]  int_en_q;
   logic [irq_w-1:0]  int_status_clr_q;
   logic              buff_addr_wen_q;
   logic [data_w-1:0] buff_addr_data_q;
   logic [1:0]        rst_cmd_q;                    // Reset command pulses
   logic [1:0][rst_stretch_len-1:0] rst_sr_q;       // Stretch shift registers

   assign wr_word = reg_wr.data;

   // Offset decode, qualified by the write strobe
   assign wr_ctrl     = reg_wr.valid & (reg_wr.off == off_ctrl);
   assign wr_glbl     = reg_wr.valid & (reg_wr.off == off_glbl_int_en);
   assign wr_int_en   = reg_wr.valid & (reg_wr.off == off_int_en);
   assign wr_int_stat = reg_wr.valid & (reg_wr.off == off_int_status);
   assign wr_buff     = reg_wr.valid & (reg_wr.off == off_buff_addr);

   ////////////////////////////////////////////////////////////////////////////
   // Stored registers and command pulses
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         ip_en_q          <= 1'b1;           // IP enabled out of reset
         glbl_int_en_q    <= 1'b0;
         int_en_q         <= '0;
         buff_addr_wen_q  <= 1'b0;
         int_status_clr_q <= '0;
         rst_cmd_q        <= '0;
      end else begin
         if (wr_ctrl)
            ip_en_q <= wr_word.ctrl_fields.ip_en;
         if (wr_glbl)
            glbl_int_en_q <= wr_word.raw[0];
         if (wr_int_en)
            int_en_q <= wr_word.irq_fields.mask;
         buff_addr_wen_q  <= wr_buff;        // One cycle push strobe
         int_status_clr_q <= wr_int_stat ? wr_word.irq_fields.mask : '0;
         rst_cmd_q[ip_idx]   <= wr_ctrl & wr_word.ctrl_fields.ip_rst;
         rst_cmd_q[fifo_idx] <= wr_ctrl & wr_word.ctrl_fields.fifo_rst;
      end
   end

   // Pushed buffer address
   always_ff @(posedge aclk) begin
      if (wr_buff)
         buff_addr_data_q <= wr_word.raw;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reset stretchers
   ////////////////////////////////////////////////////////////////////////////
   // Command bit walks through rst_stretch_len stages, output low while any set
   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         rst_sr_q <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            rst_sr_q[i] <= {rst_sr_q[i][rst_stretch_len-2:0], rst_cmd_q[i]};
         end
      end
   end

   assign dma_ctrl = '{
      buff_addr_wen:  buff_addr_wen_q,
      buff_addr_data: buff_addr_data_q,
      int_status_clr: int_status_clr_q,
      int_en:         int_en_q,
      glbl_int_en:    glbl_int_en_q,
      fifo_rstn:      ~|rst_sr_q[fifo_idx],
      ip_rstn:        ~|rst_sr_q[ip_idx],
      ip_en:          ip_en_q
   };

endmodule

// ==== verilog/vdma_reg_read.sv ====
// VDMA register read back
module vdma_reg_read (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  vdma_regs_pkg::reg_rd_t           reg_rd,
   input  vdma_regs_pkg::dma_ctrl_t         dma_ctrl,
   input  vdma_regs_pkg::dma_status_t       dma_status,
   output logic [vdma_regs_pkg::data_w-1:0] rd_data,
   output logic                             rd_valid,
   output logic                             frame_size_ren
);
   import vdma_regs_pkg::*;

   logic [rd_lat-1:0] req_sr_q;      // Request delay line
   reg_off_t          off_q;
   logic              ren_q;
   logic [data_w-1:0] frame_size_q;  // Last popped frame size
   logic [data_w-1:0] rd_data_q;
   reg_word_u         rd_word;

   ////////////////////////////////////////////////////////////////////////////
   // Request pipeline and frame-size pop
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         req_sr_q     <= '0;
         ren_q        <= 1'b0;
         frame_size_q <= '0;
      end else begin
         req_sr_q <= {req_sr_q[rd_lat-2:0], reg_rd.req};
         ren_q    <= reg_rd.req & (reg_rd.off == off_frame_size) &
                     ~dma_status.frame_size_empty;   // No pop when empty
         if (ren_q)
            frame_size_q <= dma_status.frame_size;   // Word shown with ren
      end
   end

   always_ff @(posedge aclk) begin
      if (reg_rd.req)
         off_q <= reg_rd.off;
      if (req_sr_q[rd_lat-2])
         rd_data_q <= rd_word.raw;                   // Lands with rd_valid
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read data select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_word = '0;
      case (off_q)
         off_ip_ver:      rd_word.raw = ip_version;
         off_ctrl: begin
            rd_word.ctrl_fields.fifo_rst = ~dma_ctrl.fifo_rstn;   // Active high
            rd_word.ctrl_fields.ip_rst   = ~dma_ctrl.ip_rstn;
            rd_word.ctrl_fields.ip_en    = dma_ctrl.ip_en;
         end
         off_glbl_int_en: rd_word.raw[0] = dma_ctrl.glbl_int_en;
         off_int_status:  rd_word.irq_fields.mask = dma_status.int_status;
         off_int_en:      rd_word.irq_fields.mask = dma_ctrl.int_en;
         off_frame_size:  rd_word.raw = frame_size_q;
         default:         rd_word.raw = '0;          // Unmapped or write only
      endcase
   end

   assign rd_data        = rd_data_q;
   assign rd_valid       = req_sr_q[rd_lat-1];
   assign frame_size_ren = ren_q;

endmodule

// ==== verilog/vdma_regif_top.sv ====
// VDMA register interface top
module vdma_regif_top (
   input  logic                       aclk,
   input  logic                       aresetn,
   input  vdma_regs_pkg::axil_req_t   axil_req,
   output vdma_regs_pkg::axil_rsp_t   axil_rsp,
   input  vdma_regs_pkg::dma_status_t dma_status,
   output vdma_regs_pkg::dma_ctrl_t   dma_ctrl,
   output logic                       frame_size_ren
);
   import vdma_regs_pkg::*;

   reg_wr_t           reg_wr;    // Slave to write file
   reg_rd_t           reg_rd;    // Slave to read file
   logic [data_w-1:0] rd_data;
   logic              rd_valid;

   // Bus front end
   vdma_axil_slave vdma_axil_slave_inst (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .reg_wr   (reg_wr),
      .reg_rd   (reg_rd),
      .rd_data  (rd_data),
      .rd_valid (rd_valid)
   );

   vdma_reg_write vdma_reg_write_inst (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .reg_wr   (reg_wr),
      .dma_ctrl (dma_ctrl)
   );

   // Control outputs looped back for read back
   vdma_reg_read vdma_reg_read_inst (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .reg_rd         (reg_rd),
      .dma_ctrl       (dma_ctrl),
      .dma_status     (dma_status),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid),
      .frame_size_ren (frame_size_ren)
   );

endmodule

// ==== testbench/vdma_regif_chk.sv ====
// VDMA register bus checks
module vdma_regif_chk (
   input logic                       aclk,
   input logic                       aresetn,
   input vdma_regs_pkg::axil_req_t   axil_req,
   input vdma_regs_pkg::axil_rsp_t   axil_rsp,
   input vdma_regs_pkg::dma_ctrl_t   dma_ctrl,
   input logic                       frame_size_ren
);
   import vdma_regs_pkg::*;

   int fail_count = 0;   // Read by the testbench at the end

   // Write response held until taken
   bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else begin
         $error("bvalid dropped before bready");
         fail_count = fail_count + 1;
      end

   // Read response and its data held until taken
   rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
      else begin
         $error("rvalid or rdata changed before rready");
         fail_count = fail_count + 1;
      end

   // No new write address while a response is pending
   aw_blocked: assert property (@(posedge aclk) disable iff (!aresetn)
      axil_rsp.bvalid |-> !axil_rsp.awready)
      else begin
         $error("awready high with bvalid pending");
         fail_count = fail_count + 1;
      end

   wen_single: assert property (@(posedge aclk) disable iff (!aresetn)
      dma_ctrl.buff_addr_wen |=> !dma_ctrl.buff_addr_wen)
      else begin
         $error("buff_addr_wen high for two cycles");
         fail_count = fail_count + 1;
      end

   ren_single: assert property (@(posedge aclk) disable iff (!aresetn)
      frame_size_ren |=> !frame_size_ren)
      else begin
         $error("frame_size_ren high for two cycles");
         fail_count = fail_count + 1;
      end

endmodule

bind vdma_regif_top vdma_regif_chk vdma_regif_chk_inst (
   .aclk           (aclk),
   .aresetn        (aresetn),
   .axil_req       (axil_req),
   .axil_rsp       (axil_rsp),
   .dma_ctrl       (dma_ctrl),
   .frame_size_ren (frame_size_ren)
);

// ==== testbench/tb_vdma_regif.sv ====
// VDMA register block testbench
module tb_vdma_regif;
   import vdma_regs_pkg::*;

   localparam int clk_period = 40;
   localparam int txn_budget = 90;                    // Transactions over all tests
   localparam int txn_cycles = 30;                    // Worst case per transaction
   localparam int max_cycles = txn_budget * txn_cycles + 300;

   logic        aclk;
   logic        aresetn;
   axil_req_t   axil_req;
   axil_rsp_t   axil_rsp;
   dma_status_t dma_status;
   dma_ctrl_t   dma_ctrl;
   logic        frame_size_ren;

   int        seed = 44099;
   int        cycles = 0;
   int        errors = 0;
   int        checks = 0;
   int        tests = 0;
   int        failed_tests = 0;
   int        test_errs = 0;                          // Errors before current test
   int        stall_max = 0;                          // Longest bready/rready stall
   string     cur_test = "init";
   reg_word_u exp_q[$];                               // Expected reads, issue order

   // Shadow copy of the registers
   logic              sh_ip_en;
   logic              sh_glbl;
   logic [irq_w-1:0]  sh_int_en;
   logic [data_w-1:0] sh_frame;                       // Last popped frame size

   // Pulse monitors
   int        wen_pulses = 0;
   int        clr_pulses = 0;
   int        ren_pulses = 0;
   int        ip_low = 0;
   int        fifo_low = 0;
   dma_ctrl_t wen_ctrl;
   dma_ctrl_t clr_ctrl;

   vdma_regif_top vdma_regif_top_inst (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .dma_status     (dma_status),
      .dma_ctrl       (dma_ctrl),
      .frame_size_ren (frame_size_ren)
   );

   initial begin
      aclk = 1'b0;
      forever #(clk_period / 2) aclk = ~aclk;
   end

   always @(posedge aclk) begin
      cycles++;
      if (cycles > max_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Monitors and read compare
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge aclk) begin
      if (aresetn) begin
         if (dma_ctrl.buff_addr_wen) begin
            wen_pulses++;
            wen_ctrl = dma_ctrl;                      // Snapshot at the push
         end
         if (|dma_ctrl.int_status_clr) begin
            clr_pulses++;
            clr_ctrl = dma_ctrl;
         end
         if (frame_size_ren)
            ren_pulses++;
         if (!dma_ctrl.ip_rstn)
            ip_low++;
         if (!dma_ctrl.fifo_rstn)
            fifo_low++;
      end
   end

   // R handshake on the coming edge
   always @(negedge aclk) begin
      if (aresetn && axil_rsp.rvalid && axil_req.rready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error in %s: read response with no read outstanding", cur_test);
         end else begin
            check_word(cur_test, exp_q.pop_front(), axil_rsp.rdata);
         end
      end
   end

   task automatic check_word(input string name, input reg_word_u exp, input reg_word_u act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, exp.raw, act.raw);
      end
   endtask

   task automatic check_ctrl(input string name, input dma_ctrl_t exp, input dma_ctrl_t act);
      dma_ctrl_t e;
      dma_ctrl_t a;
      e = exp;
      a = act;
      if (!e.buff_addr_wen) begin                     // Address only valid with strobe
         e.buff_addr_data = '0;
         a.buff_addr_data = '0;
      end
      checks++;
      if (a !== e) begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, e, a);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic reg_word_u model_read(input reg_off_t off);
      reg_word_u w;
      w = '0;
      case (off)
         off_ip_ver:      w.raw = 32'h0001_0000;
         off_ctrl:        w.raw[0] = sh_ip_en;        // Reset bits self clear
         off_glbl_int_en: w.raw[0] = sh_glbl;
         off_int_status:  w.raw[irq_w-1:0] = dma_status.int_status;
         off_int_en:      w.raw[irq_w-1:0] = sh_int_en;
         off_frame_size:  w.raw = dma_status.frame_size_empty ? sh_frame : dma_status.frame_size;
         default:         w = '0;
      endcase
      return w;
   endfunction

   function automatic dma_ctrl_t model_ctrl();
      dma_ctrl_t c;
      c = '0;
      c.int_en      = sh_int_en;
      c.glbl_int_en = sh_glbl;
      c.fifo_rstn   = 1'b1;
      c.ip_rstn     = 1'b1;
      c.ip_en       = sh_ip_en;
      return c;
   endfunction

   task automatic model_write(input reg_off_t off, input logic [data_w-1:0] data);
      case (off)
         off_ctrl:        sh_ip_en = data[0];
         off_glbl_int_en: sh_glbl = data[0];
         off_int_en:      sh_int_en = data[irq_w-1:0];
         default:         ;                           // Strobes and unmapped
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic next_cycle();
      @(posedge aclk);
      #2;
   endtask

   task automatic bus_write(input reg_off_t off, input logic [data_w-1:0] data);
      int stall;
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = {24'h0, off};
      while (!axil_rsp.awready)
         next_cycle();
      next_cycle();                                   // AW taken on this edge
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      while (!axil_rsp.wready)
         next_cycle();
      next_cycle();                                   // W taken, register updated
      axil_req.wvalid = 1'b0;
      model_write(off, data);
      while (!axil_rsp.bvalid)
         next_cycle();
      stall = $unsigned($random(seed)) % (stall_max + 1);
      repeat (stall) begin
         next_cycle();
         if (!axil_rsp.bvalid || axil_rsp.awready) begin
            errors++;
            $display("Error in %s: write response not held during bready stall", cur_test);
         end
      end
      if (axil_rsp.bresp != 2'b00) begin
         errors++;
         $display("ERR %s: bresp expected %h, actual %h", cur_test, 2'b00, axil_rsp.bresp);
      end
      axil_req.bready = 1'b1;
      next_cycle();
      axil_req.bready = 1'b0;
   endtask

   task automatic bus_read(input reg_off_t off);
      int stall;
      exp_q.push_back(model_read(off));
      if (off == off_frame_size && !dma_status.frame_size_empty)
         sh_frame = dma_status.frame_size;            // Popped word becomes last
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = {24'h0, off};
      while (!axil_rsp.arready)
         next_cycle();
      next_cycle();
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid)
         next_cycle();
      stall = $unsigned($random(seed)) % (stall_max + 1);
      repeat (stall) begin
         next_cycle();
         if (!axil_rsp.rvalid || axil_rsp.arready) begin
            errors++;
            $display("Error in %s: read response not held during rready stall", cur_test);
         end
      end
      if (axil_rsp.rresp != 2'b00) begin
         errors++;
         $display("ERR %s: rresp expected %h, actual %h", cur_test, 2'b00, axil_rsp.rresp);
      end
      axil_req.rready = 1'b1;
      next_cycle();                                   // Compared at the negedge before
      axil_req.rready = 1'b0;
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = errors;
   endtask

   task automatic end_test();
      tests++;
      if (errors == test_errs) begin
         $display("Test %s ok", cur_test);
      end else begin
         failed_tests++;
         $display("Test %s FAILED with %0d errors", cur_test, errors - test_errs);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      reg_off_t          off;
      logic [data_w-1:0] data;
      dma_ctrl_t         exp_ctrl;
      int                chk_fails;
      reg_off_t          read_offs [9];
      read_offs = '{off_ip_ver, off_ctrl, off_glbl_int_en, off_int_status, off_int_en,
                    off_buff_addr, off_frame_size, 8'h14, 8'hFC};
      aresetn    = 1'b0;
      axil_req   = '0;
      dma_status = '0;
      dma_status.frame_size_empty = 1'b1;
      sh_ip_en   = 1'b1;                              // IP enabled out of reset
      sh_glbl    = 1'b0;
      sh_int_en  = '0;
      sh_frame   = '0;
      repeat (5) @(posedge aclk);
      #2;
      aresetn = 1'b1;
      next_cycle();

      start_test("reset_values");
      check_ctrl("reset dma_ctrl", model_ctrl(), dma_ctrl);
      foreach (read_offs[k])
         bus_read(read_offs[k]);
      end_test();

      start_test("rw_random");
      for (int n = 0; n < 5; n++) begin
         data = $random(seed);
         bus_write(off_glbl_int_en, data);
         bus_read(off_glbl_int_en);
         data = $random(seed);
         bus_write(off_int_en, data);
         bus_read(off_int_en);
         data = $random(seed) & 32'hFFFF_FFF9;        // ip_en only, no reset commands
         bus_write(off_ctrl, data);
         bus_read(off_ctrl);
      end
      data = $random(seed);
      bus_write(8'h14, data);
      bus_write(8'hF0, data);
      bus_write(off_ip_ver, data);                    // Read only
      bus_read(8'h14);
      bus_read(8'hF0);
      bus_read(off_ip_ver);
      check_ctrl("rw dma_ctrl", model_ctrl(), dma_ctrl);
      end_test();

      start_test("cmd_pulses");
      wen_pulses = 0;
      clr_pulses = 0;
      data = $random(seed);
      bus_write(off_buff_addr, data);
      exp_ctrl = model_ctrl();
      exp_ctrl.buff_addr_wen  = 1'b1;
      exp_ctrl.buff_addr_data = data;
      check_count("buff_addr_wen pulses", 1, wen_pulses);
      check_ctrl("buff_addr push", exp_ctrl, wen_ctrl);
      data = $random(seed) | 32'h1;                   // At least one source cleared
      bus_write(off_int_status, data);
      exp_ctrl = model_ctrl();
      exp_ctrl.int_status_clr = data[irq_w-1:0];
      check_count("int_status_clr pulses", 1, clr_pulses);
      check_ctrl("int_status clear", exp_ctrl, clr_ctrl);
      data = $random(seed);
      dma_status.int_status = data[irq_w-1:0];
      bus_read(off_int_status);
      end_test();

      start_test("frame_size_fifo");
      ren_pulses = 0;
      dma_status.frame_size_empty = 1'b0;
      for (int n = 0; n < 4; n++) begin
         dma_status.frame_size = $random(seed);
         bus_read(off_frame_size);
         check_count("frame_size_ren pulses", n + 1, ren_pulses);
      end
      dma_status.frame_size_empty = 1'b1;
      dma_status.frame_size = $random(seed);          // Must not be taken
      bus_read(off_frame_size);
      bus_read(off_frame_size);
      check_count("frame_size_ren when empty", 4, ren_pulses);
      end_test();

      start_test("reset_stretch");
      ip_low   = 0;
      fifo_low = 0;
      bus_write(off_ctrl, {29'h0, 1'b0, 1'b1, sh_ip_en});
      repeat (8) next_cycle();
      check_count("ip_rstn low cycles", 4, ip_low);
      check_count("fifo_rstn low cycles", 0, fifo_low);
      check_ctrl("after ip reset", model_ctrl(), dma_ctrl);
      bus_write(off_ctrl, {29'h0, 1'b1, 1'b0, sh_ip_en});
      repeat (8) next_cycle();
      check_count("fifo_rstn low cycles", 4, fifo_low);
      check_count("ip_rstn low cycles", 4, ip_low);
      check_ctrl("after fifo reset", model_ctrl(), dma_ctrl);
      bus_read(off_ctrl);
      end_test();

      start_test("stall_random");
      stall_max = 6;
      dma_status.frame_size_empty = 1'b0;
      for (int n = 0; n < 8; n++) begin
         data = $random(seed);
         off  = (n % 2 == 0) ? off_int_en : off_glbl_int_en;
         bus_write(off, data);
         bus_read(off);
         dma_status.frame_size = $random(seed);
         bus_read(off_frame_size);
      end
      stall_max = 0;
      check_ctrl("after stalls", model_ctrl(), dma_ctrl);
      end_test();

      chk_fails = vdma_regif_top_inst.vdma_regif_chk_inst.fail_count;
      $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, failed_tests, checks, errors, chk_fails);
      if (errors == 0 && chk_fails == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
verilog/vdma_regs_pkg.sv
verilog/vdma_axil_slave.sv
verilog/vdma_reg_write.sv
verilog/vdma_reg_read.sv
verilog/vdma_regif_top.sv
testbench/vdma_regif_chk.sv
testbench/tb_vdma_regif.sv

// ==== Makefile ====
# Verilator build and run for the VDMA register block

VERILATOR ?= verilator
TOP       ?= tb_vdma_regif
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Regression passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
